//--- common/index_pkg.sv
`default_nettype none

package index_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and base types
	//////////////////////////////////////////////////////////////////////

	localparam int index_w  = 8;
	localparam int mask_w   = 16;	// Longest maskable slice
	localparam int thread_w = 8;
	localparam int offset_w = $clog2(mask_w);

	typedef logic [index_w-1:0]  index_t;
	typedef logic [mask_w-1:0]   mask_t;
	typedef logic [thread_w-1:0] thread_t;
	typedef logic [offset_w-1:0] offset_t;	// Bit position inside a mask

	//////////////////////////////////////////////////////////////////////
	// Operand selector codes
	//////////////////////////////////////////////////////////////////////

	// Code 1 reads as thread id for operand a, lane id for b and c
	typedef logic [1:0] opnd_sel_t;

	localparam opnd_sel_t sel_zero   = 2'd0;	// Thread id when picked for c
	localparam opnd_sel_t sel_thread = 2'd1;
	localparam opnd_sel_t sel_lane   = 2'd1;
	localparam opnd_sel_t sel_const  = 2'd2;
	localparam opnd_sel_t sel_orig   = 2'd3;

	//////////////////////////////////////////////////////////////////////
	// Request and result bundles
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		index_t    idx;		// Base index
		logic      slice;
		logic      masked;
		opnd_sel_t sel_a;
		opnd_sel_t sel_b;
		opnd_sel_t sel_c;
		logic      swap;	// Product becomes the minuend
		logic      sign;	// Subtract instead of add
	} idx_cfg_t;

	typedef struct packed {
		idx_cfg_t cfg;
		index_t   window;	// Zero means no wrap
		index_t   length;
		index_t   constant;
		thread_t  thread_base;
		mask_t    mask;
	} idx_req_t;

	typedef struct packed {
		logic   valid;
		index_t index;
	} idx_out_t;

endpackage

`default_nettype wire

//--- source/ii_ctrl.sv
`default_nettype none

module ii_ctrl #(
	parameter int lane_id = 0
)(
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic arm,
	input  wire logic clear,
	output logic      hold
);

	// Lane 0 keeps a one bit counter that never leaves zero
	localparam int count_w = (lane_id > 0) ? $clog2(lane_id + 1) : 1;

	logic [count_w-1:0] count;	// Cycles of hold left

	assign hold = (count != '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (arm) begin
			count <= count_w'(lane_id);	// Stagger by lane number
		end else if (clear) begin
			count <= '0;
		end else if (hold) begin
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/skip_ctrl.sv
`default_nettype none

module skip_ctrl
	import index_pkg::*;
(
	input  wire logic  clock,
	input  wire logic  reset,
	input  wire logic  start,
	input  wire logic  stall,
	input  wire mask_t mask,
	output logic       hit,
	output offset_t    offset,
	output logic       finish
);

	mask_t remain;	// Bits still to visit
	mask_t rest;	// Remain minus its lowest set bit
	logic  pending;	// Search in progress

	//////////////////////////////////////////////////////////////////////
	// Priority search for the lowest set bit
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		offset = '0;
		// Descending walk so the lowest set bit is written last
		for (int i = mask_w - 1; i >= 0; i--) begin
			if (remain[i]) begin
				offset = offset_t'(i);
			end
		end
	end

	assign rest = remain & (remain - 1'b1);

	assign hit    = pending & ~stall & (remain != '0);
	assign finish = pending & ~stall & (rest == '0);	// Also fires on empty mask

	//////////////////////////////////////////////////////////////////////
	// State
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (start) begin
			pending <= 1'b1;
		end else if (finish) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			remain <= mask;
		end else if (hit) begin
			remain <= rest;	// Drop the bit just emitted
		end
	end

	// A hit points at a set bit with nothing set below it
	assert property (@(posedge clock) disable iff (reset)
		hit |-> remain[offset] && (remain & ((mask_t'(1) << offset) - 1'b1)) == '0);

endmodule

`default_nettype wire

//--- index_unit/index_calc.sv
`default_nettype none

module index_calc
	import index_pkg::*;
#(
	parameter int lane_id = 0
)(
	input  wire index_t   orig,
	input  wire idx_cfg_t cfg,
	input  wire index_t   constant,
	input  wire thread_t  thread,
	output index_t        result
);

	index_t lane;
	index_t thread_idx;
	index_t opnd_a;
	index_t opnd_b;
	index_t opnd_c;
	index_t product;	// Wraps at index width
	index_t first;
	index_t second;

	assign lane       = index_t'(lane_id);
	assign thread_idx = index_t'(thread);

	// Operand picks, c falls back to the thread id
	always_comb begin
		case (cfg.sel_a)
			sel_thread: opnd_a = thread_idx;
			sel_const:  opnd_a = constant;
			sel_orig:   opnd_a = orig;
			default:    opnd_a = '0;
		endcase
		case (cfg.sel_b)
			sel_lane:  opnd_b = lane;
			sel_const: opnd_b = constant;
			sel_orig:  opnd_b = orig;
			default:   opnd_b = '0;
		endcase
		case (cfg.sel_c)
			sel_lane:  opnd_c = lane;
			sel_const: opnd_c = constant;
			sel_orig:  opnd_c = orig;
			default:   opnd_c = thread_idx;
		endcase
	end

	assign product = opnd_a * opnd_b;
	assign first   = cfg.swap ? product : opnd_c;
	assign second  = cfg.swap ? opnd_c : product;
	assign result  = cfg.sign ? first - second : first + second;

endmodule

`default_nettype wire

//--- index_unit/index_unit.sv
`default_nettype none

module index_unit
	import index_pkg::*;
#(
	parameter int lane_id = 0
)(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     req,
	input  wire logic     stall,
	input  wire logic     en_ii,
	input  wire idx_req_t request,
	output idx_out_t      out,
	output logic          busy,
	output logic          done
);

	logic     accept;		// Request taken this cycle
	logic     start_seq;	// Accepted request is sliced or masked
	logic     hold;
	logic     freeze;		// Lane may not advance
	logic     plain_pend;	// One beat owed for a plain request
	logic     active;		// Sliced or masked sequence running
	logic     is_masked;
	logic     is_slice;
	logic     slice_step;
	logic     last_elem;
	logic     plain_fire;
	logic     ii_arm;
	logic     beat_seen;	// A beat left since acceptance

	idx_cfg_t cfg_r;
	index_t   window_r;
	index_t   length_r;		// Zero length already read as one
	index_t   constant_r;
	thread_t  thread_r;
	index_t   count;		// Elements emitted so far
	index_t   woff;			// Offset inside the window
	index_t   woff_next;
	index_t   orig;
	index_t   calc_out;

	logic     skip_start;
	mask_t    len_mask;
	mask_t    skip_mask;
	logic     skip_hit;
	offset_t  skip_offset;
	logic     skip_finish;

	assign accept    = req & ~stall;
	assign start_seq = request.cfg.slice | request.cfg.masked;
	assign is_masked = cfg_r.masked;
	assign is_slice  = cfg_r.slice & ~cfg_r.masked;	// Masked wins over slice
	assign freeze    = stall | hold;

	//////////////////////////////////////////////////////////////////////
	// Element pacing
	//////////////////////////////////////////////////////////////////////

	assign plain_fire = plain_pend & ~stall;
	assign slice_step = active & is_slice & ~freeze;
	assign last_elem  = (count == length_r - 1'b1);
	assign woff_next  = (woff + 1'b1 == window_r) ? '0 : woff + 1'b1;

	assign orig = is_masked ? cfg_r.idx + index_t'(skip_offset)
	                        : cfg_r.idx + woff;

	assign out.valid = plain_fire | slice_step | (active & is_masked & skip_hit);
	assign out.index = calc_out;
	assign busy      = active;
	assign done      = plain_fire | (slice_step & last_elem)
	                 | (active & is_masked & skip_finish);

	always_ff @(posedge clock) begin
		if (reset) begin
			plain_pend <= 1'b0;
			active     <= 1'b0;
		end else if (!stall) begin
			plain_pend <= req & ~start_seq;
			if (req) begin
				active <= start_seq;
			end else if (done) begin
				active <= 1'b0;
			end
		end
	end

	// Element and window counters
	always_ff @(posedge clock) begin
		if (reset || accept) begin
			count <= '0;
			woff  <= '0;
		end else if (slice_step) begin
			count <= count + 1'b1;
			woff  <= woff_next;
		end
	end

	always_ff @(posedge clock) begin
		if (reset || accept) begin
			beat_seen <= 1'b0;
		end else if (out.valid) begin
			beat_seen <= 1'b1;
		end
	end

	// Configuration captured on acceptance
	always_ff @(posedge clock) begin
		if (accept) begin
			cfg_r      <= request.cfg;
			window_r   <= request.window;
			length_r   <= (request.length == '0) ? index_t'(1) : request.length;
			constant_r <= request.constant;
			thread_r   <= request.thread_base + thread_t'(lane_id);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Submodules
	//////////////////////////////////////////////////////////////////////

	// Only mask bits below length take part
	always_comb begin
		if (request.length >= index_t'(mask_w)) begin
			len_mask = '1;
		end else begin
			len_mask = (mask_t'(1) << request.length) - 1'b1;
		end
	end

	assign skip_mask  = request.mask & len_mask;
	assign skip_start = accept & request.cfg.masked;
	assign ii_arm     = accept & start_seq & en_ii;

	index_calc #(
		.lane_id (lane_id)
	) u_calc (
		.orig     (orig),
		.cfg      (cfg_r),
		.constant (constant_r),
		.thread   (thread_r),
		.result   (calc_out)
	);

	skip_ctrl u_skip (
		.clock  (clock),
		.reset  (reset),
		.start  (skip_start),
		.stall  (freeze),		// Hold also parks the search
		.mask   (skip_mask),
		.hit    (skip_hit),
		.offset (skip_offset),
		.finish (skip_finish)
	);

	ii_ctrl #(
		.lane_id (lane_id)
	) u_ii (
		.clock (clock),
		.reset (reset),
		.arm   (ii_arm),
		.clear (done),
		.hold  (hold)
	);

	// Driver holds off until every lane has drained
	assert property (@(posedge clock) disable iff (reset) req |-> !busy);

	// A done without a beat only ends a masked read that found no set bit
	assert property (@(posedge clock) disable iff (reset)
		done && !out.valid |-> is_masked && !beat_seen);

endmodule

`default_nettype wire

//--- source/index_top.sv
`default_nettype none

module index_top
	import index_pkg::*;
#(
	parameter int num_lanes = 4
)(
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 req,
	input  wire logic                 stall,
	input  wire logic                 en_ii,
	input  wire idx_req_t             request,
	output wire idx_out_t             outs [num_lanes],
	output wire logic [num_lanes-1:0] busy,
	output wire logic [num_lanes-1:0] done
);

	//////////////////////////////////////////////////////////////////////
	// Lane array
	//////////////////////////////////////////////////////////////////////

	// Request, strobe and levels go to every lane unchanged
	for (genvar lane = 0; lane < num_lanes; lane++) begin : g_lane
		index_unit #(
			.lane_id (lane)
		) u_unit (
			.clock   (clock),
			.reset   (reset),
			.req     (req),
			.stall   (stall),
			.en_ii   (en_ii),
			.request (request),
			.out     (outs[lane]),
			.busy    (busy[lane]),
			.done    (done[lane])
		);
	end

endmodule

`default_nettype wire

//--- bench/index_model.svh
`ifndef INDEX_MODEL_SVH
`define INDEX_MODEL_SVH

typedef index_t index_list_t[$];

// Expected index for one element of one lane
function automatic index_t model_index(idx_req_t r, index_t orig, int lane);
	index_t thread;
	index_t lane_v;
	index_t a;
	index_t b;
	index_t c;
	index_t prod;
	thread = index_t'(r.thread_base + thread_t'(lane));
	lane_v = index_t'(lane);
	case (r.cfg.sel_a)
		sel_thread: a = thread;
		sel_const:  a = r.constant;
		sel_orig:   a = orig;
		default:    a = '0;
	endcase
	case (r.cfg.sel_b)
		sel_lane:  b = lane_v;
		sel_const: b = r.constant;
		sel_orig:  b = orig;
		default:   b = '0;
	endcase
	case (r.cfg.sel_c)
		sel_lane:  c = lane_v;
		sel_const: c = r.constant;
		sel_orig:  c = orig;
		default:   c = thread;		// Code 0 means thread id here
	endcase
	prod = index_t'(a * b);
	if (r.cfg.swap) begin
		return r.cfg.sign ? prod - c : prod + c;
	end
	return r.cfg.sign ? c - prod : c + prod;
endfunction

// Ordered list of indices that a lane must produce for a request
function automatic index_list_t expected_indices(idx_req_t r, int lane);
	index_list_t seq;
	int count;
	int k;
	int offset;
	seq = {};
	if (r.cfg.masked) begin
		for (k = 0; k < mask_w; k++) begin
			if (k < int'(r.length) && r.mask[k]) begin
				seq.push_back(model_index(r, r.cfg.idx + index_t'(k), lane));
			end
		end
	end else if (r.cfg.slice) begin
		count = (r.length == '0) ? 1 : int'(r.length);	// Zero length gives one element
		for (k = 0; k < count; k++) begin
			offset = (r.window == '0) ? k : k % int'(r.window);
			seq.push_back(model_index(r, r.cfg.idx + index_t'(offset), lane));
		end
	end else begin
		seq.push_back(model_index(r, r.cfg.idx, lane));
	end
	return seq;
endfunction

`endif

//--- bench/tb_index_top.sv
`default_nettype none

module tb_index_top
	import index_pkg::*;
();

	localparam int num_lanes    = 4;
	localparam int seed         = 28929;
	localparam int num_requests = 200;
	localparam int max_length   = 2 * mask_w;	// Sliced lengths stay below this
	localparam int stall_budget = 24;			// Stall cycles per request at most
	localparam int stall_allow  = 32;
	localparam int cycle_limit  = num_requests * (2 * mask_w + num_lanes + stall_allow);

	localparam int kind_plain  = 0;
	localparam int kind_slice  = 1;
	localparam int kind_masked = 2;

	logic                 clock;
	logic                 reset;
	logic                 req;
	logic                 stall;
	logic                 en_ii;
	idx_req_t             request;
	idx_out_t             outs [num_lanes];
	logic [num_lanes-1:0] busy;
	logic [num_lanes-1:0] done;

	`include "index_model.svh"

	index_t               expect_q [num_lanes][$];
	int                   first_valid [num_lanes];	// -1 until the first beat
	logic [num_lanes-1:0] done_seen;
	int                   cycle;
	int                   accept_cycle;
	int                   stall_count;
	int                   n;
	bit                   check_timing;
	bit                   req_ii;
	bit                   req_plain;
	string                test_name;

	index_top #(
		.num_lanes (num_lanes)
	) dut (
		.clock   (clock),
		.reset   (reset),
		.req     (req),
		.stall   (stall),
		.en_ii   (en_ii),
		.request (request),
		.outs    (outs),
		.busy    (busy),
		.done    (done)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
		end
	endtask

	task automatic check_idle(string name);
		int lane;
		for (lane = 0; lane < num_lanes; lane++) begin
			compare_value({name, " valid"}, 32'd0, 32'(outs[lane].valid));
		end
		compare_value({name, " busy"}, 32'd0, 32'(busy));
		compare_value({name, " done"}, 32'd0, 32'(done));
	endtask

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			abort_run($sformatf("Timeout after %0d cycles, the DUT seems to hang", cycle));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Per-lane monitor
	//////////////////////////////////////////////////////////////////////

	task automatic monitor_lane(int lane);
		string  name;
		index_t want;
		name = $sformatf("%s lane %0d", test_name, lane);
		if (stall) begin
			compare_value({name, " valid in stall"}, 32'd0, 32'(outs[lane].valid));
		end
		if (req_plain) begin
			compare_value({name, " busy"}, 32'd0, 32'(busy[lane]));
		end
		if (outs[lane].valid) begin
			if (expect_q[lane].size() == 0) begin
				abort_run($sformatf("%s gave an output that was not expected", name));
			end
			want = expect_q[lane].pop_front();
			compare_value({name, " index"}, 32'(want), 32'(outs[lane].index));
			if (!req_plain) begin
				compare_value({name, " busy"}, 32'd1, 32'(busy[lane]));
			end
			if (first_valid[lane] < 0) begin
				first_valid[lane] = cycle;
				if (check_timing) begin
					compare_value({name, " first beat cycle"},
						32'(accept_cycle + 1 + (req_ii ? lane : 0)), 32'(cycle));
				end
				if (req_ii && first_valid[0] >= 0) begin	// Stagger against lane 0
					compare_value({name, " stagger"}, 32'(lane),
						32'(first_valid[lane] - first_valid[0]));
				end
			end
			compare_value({name, " done"}, 32'(expect_q[lane].size() == 0), 32'(done[lane]));
		end else if (done[lane] && expect_q[lane].size() != 0) begin
			abort_run($sformatf("%s signalled done with outputs still missing", name));
		end
		if (done[lane]) begin
			done_seen[lane] = 1'b1;
		end
	endtask

	always @(negedge clock) begin : monitor
		int lane;
		if (!reset) begin
			if (req && !stall) begin
				accept_cycle = cycle;
			end
			for (lane = 0; lane < num_lanes; lane++) begin
				monitor_lane(lane);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	function automatic idx_req_t random_request(int kind);
		idx_req_t r;
		r.cfg.idx         = index_t'($urandom);
		r.cfg.slice       = (kind == kind_slice);
		r.cfg.masked      = (kind == kind_masked);
		r.cfg.sel_a       = opnd_sel_t'($urandom);
		r.cfg.sel_b       = opnd_sel_t'($urandom);
		r.cfg.sel_c       = opnd_sel_t'($urandom);
		r.cfg.swap        = 1'($urandom);
		r.cfg.sign        = 1'($urandom);
		r.window          = index_t'($urandom % 9);	// Zero included
		r.length          = (kind == kind_masked) ? index_t'($urandom % (mask_w + 4))
		                                          : index_t'($urandom % max_length);
		r.constant        = index_t'($urandom);
		r.thread_base     = thread_t'($urandom);
		r.mask            = mask_t'($urandom);
		if (kind == kind_masked && $urandom % 5 == 0) begin
			r.mask = '0;
		end
		return r;
	endfunction

	function automatic logic next_stall(bit with_stall);
		if (with_stall && stall_count < stall_budget && $urandom % 4 == 0) begin
			stall_count++;
			return 1'b1;
		end
		return 1'b0;
	endfunction

	// Called one time unit after a rising edge; returns at the same point
	task automatic run_request(int kind, bit with_stall, bit with_ii, string name);
		idx_req_t r;
		int       lane;
		bit       accepted;
		r = random_request(kind);
		for (lane = 0; lane < num_lanes; lane++) begin
			expect_q[lane]    = expected_indices(r, lane);
			first_valid[lane] = -1;
		end
		done_seen    = '0;
		test_name    = name;
		check_timing = !with_stall;
		req_ii       = with_ii;
		req_plain    = (kind == kind_plain);
		stall_count  = 0;
		request      = r;
		en_ii        = with_ii;
		req          = 1'b1;
		accepted     = 1'b0;
		while (!accepted) begin
			stall    = next_stall(with_stall);
			accepted = !stall;
			@(posedge clock);
			#1;
		end
		req = 1'b0;
		while (done_seen != '1) begin
			stall = next_stall(with_stall);
			@(posedge clock);
			#1;
		end
		stall = 1'b0;
	endtask

	initial begin
		void'($urandom(seed));
		cycle   = 0;
		reset   = 1'b1;
		req     = 1'b0;
		stall   = 1'b0;
		en_ii   = 1'b0;
		request = '0;
		repeat (3) begin
			@(posedge clock);
			#1;
			check_idle("reset");
		end
		reset = 1'b0;
		@(negedge clock);
		check_idle("after reset");
		@(posedge clock);
		#1;

		for (n = 0; n < num_requests; n++) begin
			case (n % 5)
				0: run_request(kind_plain, 1'b0, 1'b0, "plain");
				1: run_request(kind_slice, 1'b0, 1'b0, "sliced");
				2: run_request(kind_masked, 1'b0, 1'b0, "masked");
				3: run_request(($urandom % 2) ? kind_masked : kind_slice, 1'b1, 1'b0, "stall");
				default: run_request(($urandom % 2) ? kind_masked : kind_slice, 1'b0, 1'b1,
					"initiation interval");
			endcase
		end

		compare_value("final busy", 32'd0, 32'(busy));
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+bench
common/index_pkg.sv
source/ii_ctrl.sv
source/skip_ctrl.sv
index_unit/index_calc.sv
index_unit/index_unit.sv
source/index_top.sv
bench/tb_index_top.sv

//--- run.sh
#!/bin/sh
# Build and run the index stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_index_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_index_top)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q -F '** PASS **'; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
